// ==== vlog.f ====
+incdir+test
source/iq_pkg.sv
source/issue_if.sv
source/wb_if.sv
source/issue_queue.sv
source/insn_decode.sv
source/alu_execute.sv
source/reg_writeback.sv
source/dual_issue_top.sv
test/tb_dual_issue.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_dual_issue
FILELIST = vlog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== test/tb_stim.svh ====
// ------------------------------------------------
// issue queue stimulus table
// ------------------------------------------------
// row: {push mask[3:0], lane 0, lane 1, lane 2, lane 3, clear}
// insn: op[7:6] dst[5:4] imm[3:0], op 0 ldi, 1 addi, 2 xori, 3 shli

localparam int NUM_ROWS = 22;

localparam logic [36:0] STIM_TAB [NUM_ROWS] = '{
  // independent pairs, then back to back dependences
  {4'b1111, 8'h05, 8'h19, 8'h43, 8'h96, 1'b0},  // ldi r0,5 ldi r1,9 addi r0,3 xori r1,6
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b1111, 8'hC1, 8'h4F, 8'hA3, 8'hE4, 1'b0},  // shli r0,1 addi r0,15 xori r2,3 shli r2,4
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  // one destination only, single issue, queue climbs to 7
  {4'b1111, 8'h31, 8'h71, 8'h72, 8'h73, 1'b0},
  {4'b1111, 8'hBF, 8'hF1, 8'h74, 8'h75, 1'b0},
  {4'b0001, 8'h76, 8'h00, 8'h00, 8'h00, 1'b0},  // one free slot
  {4'b0001, 8'hF3, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0011, 8'h77, 8'hB5, 8'h00, 8'h00, 1'b0},  // two free slots
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  // clear drops what is left, then a fresh bundle
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b1},
  {4'b1111, 8'h71, 8'h8F, 8'h52, 8'hE1, 1'b0},  // addi r3,1 xori r0,15 addi r1,2 shli r2,1
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0},
  {4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0}
};

// ==== test/tb_dual_issue.sv ====
// ------------------------------------------------
// dual issue machine testbench
// ------------------------------------------------
module tb_dual_issue;
  timeunit 1ns;
  timeprecision 1ps;
  import iq_pkg::*;

  `include "tb_stim.svh"

  localparam int TIMEOUT_CYC = NUM_ROWS + 40;

  logic                   clk;
  logic                   rst_n;
  logic                   clear;
  logic [PUSH_W-1:0]      push;
  insn_t [PUSH_W-1:0]     datain;
  logic                   full;
  logic [PUSH_W-1:1]      almost_full;
  logic                   empty;
  logic [ISSUE_W-1:0]     retire_valid;
  reg_idx_t [ISSUE_W-1:0] retire_dst;
  data_t [ISSUE_W-1:0]    retire_value;

  insn_t      mq[$];      // modelled queue contents, oldest first
  logic [9:0] exp_q[$];   // {dst, value} in program order
  data_t      mrf [NUM_REGS];
  int         err_cnt = 0;
  int         fail_cnt = 0;
  int         retired = 0;
  int         cyc_cnt = 0;
  logic       run_model = 1'b0;

  dual_issue_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .push         (push),
    .datain       (datain),
    .full         (full),
    .almost_full  (almost_full),
    .empty        (empty),
    .retire_valid (retire_valid),
    .retire_dst   (retire_dst),
    .retire_value (retire_value)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles, retire stream never drained", cyc_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  // isa rules, imm zero extended
  function automatic data_t isa_result(insn_t insn, data_t cur);
    data_t imm8;
    data_t res;
    imm8 = {4'h0, insn[3:0]};
    case (insn[7:6])
      2'd0:    res = imm8;
      2'd1:    res = cur + imm8;
      2'd2:    res = cur ^ (imm8 * 8'h11);  // nibble repeated
      default: res = cur << insn[2:0];
    endcase
    return res;
  endfunction

  task automatic report_mismatch(string name, int got, int want);
    err_cnt++;
    $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, want);
  endtask

  task automatic check_flags();
    int                cnt;
    logic [PUSH_W-1:1] exp_af;
    cnt = mq.size();
    for (int j = 1; j < PUSH_W; j++) begin
      exp_af[j] = (IQ_DEPTH - cnt <= j);  // j or fewer free entries
    end
    assert (full == (cnt == IQ_DEPTH))
      else report_mismatch("full", int'(full), int'(cnt == IQ_DEPTH));
    assert (almost_full == exp_af)
      else report_mismatch("almost_full", int'(almost_full), int'(exp_af));
    assert (empty == (cnt == 0))
      else report_mismatch("empty", int'(empty), int'(cnt == 0));
  endtask

  task automatic check_retire();
    logic [9:0] want;
    assert (!retire_valid[1] || retire_valid[0]) else begin
      fail_cnt++;
      $display("%0t: retire slot 1 valid without slot 0", $time);
    end
    for (int s = 0; s < ISSUE_W; s++) begin
      if (retire_valid[s]) begin
        assert (exp_q.size() != 0) else begin
          fail_cnt++;
          $display("%0t: slot %0d retired with nothing outstanding", $time, s);
        end
        if (exp_q.size() != 0) begin
          want = exp_q.pop_front();
          retired++;
          assert (retire_dst[s] == want[9:8])
            else report_mismatch($sformatf("retire_dst[%0d]", s),
                                 int'(retire_dst[s]), int'(want[9:8]));
          assert (retire_value[s] == want[7:0])
            else report_mismatch($sformatf("retire_value[%0d]", s),
                                 int'(retire_value[s]), int'(want[7:0]));
        end
      end
    end
    if (&retire_valid) begin
      assert (retire_dst[0] != retire_dst[1]) else begin
        fail_cnt++;
        $display("%0t: both retire slots wrote r%0d", $time, retire_dst[0]);
      end
    end
  endtask

  // what the coming edge does to the queue
  task automatic step_model();
    int    npop;
    insn_t ins;
    npop = 0;
    if (mq.size() >= 1)
      npop = 1;
    if (mq.size() >= 2 && mq[1][5:4] != mq[0][5:4])
      npop = 2;
    for (int k = 0; k < npop; k++) begin
      ins = mq.pop_front();
      mrf[ins[5:4]] = isa_result(ins, mrf[ins[5:4]]);
      exp_q.push_back({ins[5:4], mrf[ins[5:4]]});
    end
    if (clear) begin
      mq.delete();  // popped ones still retire
    end else begin
      for (int j = 0; j < PUSH_W; j++) begin
        if (push[j])
          mq.push_back(datain[j]);
      end
    end
  endtask

  always @(negedge clk) begin
    if (run_model) begin
      check_flags();
      check_retire();
      step_model();
    end
  end

  initial begin
    rst_n  = 1'b0;
    clear  = 1'b0;
    push   = '0;
    datain = '0;
    for (int r = 0; r < NUM_REGS; r++) begin
      mrf[r] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    assert (retire_valid == '0)
      else report_mismatch("retire_valid", int'(retire_valid), 0);
    assert (full == 1'b0) else report_mismatch("full", int'(full), 0);
    assert (empty == 1'b1) else report_mismatch("empty", int'(empty), 1);
    @(posedge clk);
    rst_n     <= 1'b1;
    run_model <= 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk);
      push  <= STIM_TAB[r][36:33];
      clear <= STIM_TAB[r][0];
      for (int j = 0; j < PUSH_W; j++) begin
        datain[j] <= STIM_TAB[r][32-8*j -: 8];
      end
    end
    @(posedge clk);
    push  <= '0;
    clear <= 1'b0;

    while (mq.size() != 0 || exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);  // no late retire of cleared entries

    $display("retired %0d, value errors %0d, other failures %0d",
             retired, err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== source/dual_issue_top.sv ====
// ------------------------------------------------
// dual issue register machine
// ------------------------------------------------
module dual_issue_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   clear,
  input  logic [iq_pkg::PUSH_W-1:0]              push,
  input  iq_pkg::insn_t [iq_pkg::PUSH_W-1:0]     datain,
  output logic                                   full,
  output logic [iq_pkg::PUSH_W-1:1]              almost_full,
  output logic                                   empty,
  output logic [iq_pkg::ISSUE_W-1:0]             retire_valid,
  output iq_pkg::reg_idx_t [iq_pkg::ISSUE_W-1:0] retire_dst,
  output iq_pkg::data_t [iq_pkg::ISSUE_W-1:0]    retire_value
);
  import iq_pkg::*;

  insn_t [ISSUE_W-1:0] q_dataout;     // queue head entries
  logic  [ISSUE_W-1:1] q_almost_empty;
  logic  [ISSUE_W-1:0] q_pop;

  issue_if iss ();
  wb_if    wb ();

  issue_queue u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .push         (push),
    .datain       (datain),
    .full         (full),
    .almost_full  (almost_full),
    .pop          (q_pop),
    .dataout      (q_dataout),
    .empty        (empty),
    .almost_empty (q_almost_empty)
  );

  insn_decode u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .dataout      (q_dataout),
    .empty        (empty),
    .almost_empty (q_almost_empty),
    .pop          (q_pop),
    .iss          (iss.source)
  );

  alu_execute u_execute (
    .clk   (clk),
    .rst_n (rst_n),
    .iss   (iss.sink),
    .wb    (wb.source)
  );

  reg_writeback u_writeback (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb           (wb.sink),
    .retire_valid (retire_valid),
    .retire_dst   (retire_dst),
    .retire_value (retire_value)
  );

endmodule

// ==== source/reg_writeback.sv ====
// ------------------------------------------------
// register file and retire ports
// ------------------------------------------------
module reg_writeback (
  input  logic                                   clk,
  input  logic                                   rst_n,
  wb_if.sink                                     wb,
  output logic [iq_pkg::ISSUE_W-1:0]             retire_valid,
  output iq_pkg::reg_idx_t [iq_pkg::ISSUE_W-1:0] retire_dst,
  output iq_pkg::data_t [iq_pkg::ISSUE_W-1:0]    retire_value
);
  import iq_pkg::*;

  data_t rf [NUM_REGS];

  // architectural registers read as zero after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        rf[r] <= '0;
      end
    end else begin
      for (int i = 0; i < ISSUE_W; i++) begin
        if (wb.valid[i])
          rf[wb.dst[i]] <= wb.value[i];
      end
    end
  end

  for (genvar i = 0; i < ISSUE_W; i++) begin : g_rd
    assign wb.rd_data[i] = rf[wb.rd_sel[i]];  // no bypass here, execute forwards
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      retire_valid <= '0;
    else
      retire_valid <= wb.valid;
  end

  always_ff @(posedge clk) begin
    retire_dst   <= wb.dst;
    retire_value <= wb.value;
  end

  // both write ports hit the same register only if decode pairing broke
  a_wr_dst: assert property (@(posedge clk) disable iff (!rst_n)
    (&wb.valid) |-> (wb.dst[0] != wb.dst[1]))
    else $error("reg_writeback: both slots write r%0d", wb.dst[0]);

endmodule

// ==== source/alu_execute.sv ====
// ------------------------------------------------
// operand select and alu
// ------------------------------------------------
module alu_execute (
  input  logic    clk,
  input  logic    rst_n,
  issue_if.sink   iss,
  wb_if.source    wb
);
  import iq_pkg::*;

  data_t opnd   [ISSUE_W];
  data_t result [ISSUE_W];

  function automatic data_t alu_op(opcode_e op, data_t a, imm_t imm);
    data_t r;
    case (op)
      LDI:     r = {4'b0000, imm};
      ADDI:    r = a + {4'b0000, imm};  // wraps mod 256
      XORI:    r = a ^ {imm, imm};
      SHLI:    r = a << imm[2:0];
      default: r = a;
    endcase
    return r;
  endfunction

  // each op reads its own destination register
  assign wb.rd_sel = iss.dst;

  always_comb begin
    for (int i = 0; i < ISSUE_W; i++) begin
      // result stage slots not yet in the register file
      if (wb.valid[1] && (wb.dst[1] == iss.dst[i]))
        opnd[i] = wb.value[1];
      else if (wb.valid[0] && (wb.dst[0] == iss.dst[i]))
        opnd[i] = wb.value[0];
      else
        opnd[i] = wb.rd_data[i];
      result[i] = alu_op(iss.op[i], opnd[i], iss.imm[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      wb.valid <= '0;
    else
      wb.valid <= iss.valid;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < ISSUE_W; i++) begin
      wb.dst[i]   <= iss.dst[i];
      wb.value[i] <= result[i];
    end
  end

endmodule

// ==== source/insn_decode.sv ====
// ------------------------------------------------
// instruction decode and pop control
// ------------------------------------------------
module insn_decode (
  input  logic                                clk,
  input  logic                                rst_n,
  input  iq_pkg::insn_t [iq_pkg::ISSUE_W-1:0] dataout,
  input  logic                                empty,
  input  logic [iq_pkg::ISSUE_W-1:1]          almost_empty,
  output logic [iq_pkg::ISSUE_W-1:0]          pop,
  issue_if.source                             iss
);
  import iq_pkg::*;

  opcode_e  [ISSUE_W-1:0] head_op;
  reg_idx_t [ISSUE_W-1:0] head_dst;
  imm_t     [ISSUE_W-1:0] head_imm;

  // field split of the two head entries
  always_comb begin
    for (int i = 0; i < ISSUE_W; i++) begin
      head_op[i]  = opcode_e'(dataout[i][7:6]);
      head_dst[i] = dataout[i][5:4];
      head_imm[i] = dataout[i][3:0];
    end
  end

  // second slot only with two entries and no shared destination
  assign pop[0] = !empty;
  assign pop[1] = !almost_empty[1] && (head_dst[1] != head_dst[0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      iss.valid <= '0;
    else
      iss.valid <= pop;
  end

  always_ff @(posedge clk) begin
    iss.op  <= head_op;
    iss.dst <= head_dst;
    iss.imm <= head_imm;
  end

  // paired issue never shares a destination
  a_pair_ok: assert property (@(posedge clk) disable iff (!rst_n)
    iss.valid[1] |-> (iss.valid[0] && (iss.dst[1] != iss.dst[0])))
    else $error("insn_decode: bad slot 1 issue");

endmodule

// ==== source/issue_queue.sv ====
// ------------------------------------------------
// wide instruction issue queue
// ------------------------------------------------
module issue_queue (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                clear,
  input  logic [iq_pkg::PUSH_W-1:0]           push,
  input  iq_pkg::insn_t [iq_pkg::PUSH_W-1:0]  datain,
  output logic                                full,
  output logic [iq_pkg::PUSH_W-1:1]           almost_full,
  input  logic [iq_pkg::ISSUE_W-1:0]          pop,
  output iq_pkg::insn_t [iq_pkg::ISSUE_W-1:0] dataout,
  output logic                                empty,
  output logic [iq_pkg::ISSUE_W-1:1]          almost_empty
);
  import iq_pkg::*;

  insn_t               mem [IQ_DEPTH];
  logic [IQ_PTR_W-1:0] wptr;
  logic [IQ_PTR_W-1:0] rptr;
  logic [IQ_CNT_W-1:0] count;      // occupied entries
  logic [IQ_CNT_W-1:0] push_cnt;
  logic [IQ_CNT_W-1:0] pop_cnt;
  logic [IQ_PTR_W-1:0] lane_ofs [PUSH_W];

  // set lanes are packed onto consecutive slots
  always_comb begin
    push_cnt = '0;
    for (int j = 0; j < PUSH_W; j++) begin
      lane_ofs[j] = push_cnt[IQ_PTR_W-1:0];  // set lanes below j
      push_cnt    = push_cnt + IQ_CNT_W'(push[j]);
    end
  end

  always_comb begin
    pop_cnt = '0;
    for (int j = 0; j < ISSUE_W; j++) begin
      pop_cnt = pop_cnt + IQ_CNT_W'(pop[j]);
    end
  end

  // pointers wrap modulo depth by truncation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (clear) begin
      // queue contents dropped, already popped slots go on
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr + push_cnt[IQ_PTR_W-1:0];
      rptr  <= rptr + pop_cnt[IQ_PTR_W-1:0];
      count <= count + push_cnt - pop_cnt;
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < PUSH_W; j++) begin
      if (push[j])
        mem[wptr + lane_ofs[j]] <= datain[j];
    end
  end

  // head entries, slot 0 oldest
  for (genvar i = 0; i < ISSUE_W; i++) begin : g_head
    assign dataout[i] = mem[rptr + IQ_PTR_W'(i)];
  end

  assign full  = (count == IQ_CNT_W'(IQ_DEPTH));
  assign empty = (count == '0);

  for (genvar i = 1; i < PUSH_W; i++) begin : g_afull
    assign almost_full[i] = (count >= IQ_CNT_W'(IQ_DEPTH - i));  // i slots or fewer free
  end

  for (genvar i = 1; i < ISSUE_W; i++) begin : g_aempty
    assign almost_empty[i] = (count <= IQ_CNT_W'(i));
  end

  // overflow per push lane
  a_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(push[0] && full))
    else $error("issue_queue: push lane 0 while full");

  for (genvar i = 1; i < PUSH_W; i++) begin : g_ovf
    a_push_afull: assert property (@(posedge clk) disable iff (!rst_n)
      !(push[i] && almost_full[i]))
      else $error("issue_queue: push lane %0d while almost_full[%0d]", i, i);
  end

  // underflow per pop lane
  a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !(pop[0] && empty))
    else $error("issue_queue: pop lane 0 while empty");

  for (genvar i = 1; i < ISSUE_W; i++) begin : g_udf
    a_pop_aempty: assert property (@(posedge clk) disable iff (!rst_n)
      !(pop[i] && almost_empty[i]))
      else $error("issue_queue: pop lane %0d while almost_empty[%0d]", i, i);
  end

endmodule

// ==== source/wb_if.sv ====
// ------------------------------------------------
// execute results and register reads
// ------------------------------------------------
interface wb_if;
  import iq_pkg::*;

  logic     [ISSUE_W-1:0] valid;
  reg_idx_t [ISSUE_W-1:0] dst;
  data_t    [ISSUE_W-1:0] value;
  reg_idx_t [ISSUE_W-1:0] rd_sel;   // operand read index per slot
  data_t    [ISSUE_W-1:0] rd_data;  // combinational read data

  modport source (
    output valid, dst, value, rd_sel,
    input  rd_data
  );

  modport sink (
    input  valid, dst, value, rd_sel,
    output rd_data
  );

endinterface

// ==== source/issue_if.sv ====
// ------------------------------------------------
// decode to execute issue slots
// ------------------------------------------------
interface issue_if;
  import iq_pkg::*;

  logic     [ISSUE_W-1:0] valid;  // slot 0 is the older one
  opcode_e  [ISSUE_W-1:0] op;
  reg_idx_t [ISSUE_W-1:0] dst;
  imm_t     [ISSUE_W-1:0] imm;

  modport source (
    output valid,
    output op,
    output dst,
    output imm
  );

  modport sink (
    input valid,
    input op,
    input dst,
    input imm
  );

endinterface

// ==== source/iq_pkg.sv ====
// ------------------------------------------------
// dual issue machine shared types
// ------------------------------------------------
package iq_pkg;

  // bundle and issue geometry
  localparam int PUSH_W   = 4;  // instructions per push bundle
  localparam int ISSUE_W  = 2;  // popped / issued per cycle

  // queue geometry, depth is a power of two so pointers wrap on their own
  localparam int IQ_DEPTH = 8;
  localparam int IQ_PTR_W = 3;
  localparam int IQ_CNT_W = 4;  // holds 0..IQ_DEPTH

  localparam int NUM_REGS = 4;

  typedef logic [7:0] insn_t;     // {op[7:6], dst[5:4], imm[3:0]}
  typedef logic [7:0] data_t;
  typedef logic [1:0] reg_idx_t;
  typedef logic [3:0] imm_t;

  typedef enum logic [1:0] {
    LDI  = 2'd0,  // dst = imm
    ADDI = 2'd1,  // dst = dst + imm
    XORI = 2'd2,  // dst = dst ^ {imm, imm}
    SHLI = 2'd3   // dst = dst << imm[2:0]
  } opcode_e;

endpackage
